// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // data word or address
    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_addr_t;

    // boot rom base, first fetch after reset
    localparam word_t RESET_PC = 32'hBFC0_0000;

    localparam int NUM_REGS = 32;

endpackage

`default_nettype wire

// ==== hw/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_SLTIU   = 6'h0B,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F
    } opcode_e;

    // special function field, kept r-type ops only
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        alu_op_e             alu_op;
        logic                src_a_shamt;
        logic                src_b_imm;
        core_pkg::word_t     imm_value;
        logic                reg_wen;
        core_pkg::reg_addr_t reg_waddr;
        core_pkg::reg_addr_t rs;
        core_pkg::reg_addr_t rt;
    } dec_ctrl_t;

    // pipeline packets
    typedef struct packed {
        logic            valid;
        core_pkg::word_t pc;
        core_pkg::word_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic                valid;
        core_pkg::word_t     pc;
        alu_op_e             alu_op;
        core_pkg::word_t     src_a;
        core_pkg::word_t     src_b;
        logic                reg_wen;
        core_pkg::reg_addr_t reg_waddr;
    } exe_pkt_t;

    typedef struct packed {
        logic                valid;
        core_pkg::word_t     pc;
        logic                reg_wen;
        core_pkg::reg_addr_t reg_waddr;
        core_pkg::word_t     result;
    } wb_pkt_t;

endpackage

`default_nettype wire

// ==== hw/pc_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_fetch (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                inst_data_ok_i,
    input  core_pkg::word_t     inst_rdata_i,
    output logic                inst_req_o,
    output core_pkg::word_t     inst_addr_o,
    output isa_pkg::fetch_pkt_t fetch_o
);
    import core_pkg::*;

    word_t pc_q;
    logic  req_q;
    logic  accept;

    // word taken at the edge where data_ok meets an open request
    assign accept      = req_q & inst_data_ok_i;
    assign inst_req_o  = req_q;
    assign inst_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            req_q         <= 1'b0;
            pc_q          <= RESET_PC;
            fetch_o.valid <= 1'b0;
        end else begin
            req_q         <= 1'b1;
            fetch_o.valid <= accept;
            fetch_o.pc    <= pc_q;
            fetch_o.inst  <= inst_rdata_i;
            if (accept) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  core_pkg::word_t    inst_i,
    output isa_pkg::dec_ctrl_t ctrl_o
);
    import core_pkg::*;
    import isa_pkg::*;

    opcode_e   op;
    funct_e    fn;
    reg_addr_t rd;
    word_t     imm_sext;
    word_t     imm_zext;
    logic      known;
    logic      use_rd;

    assign op       = opcode_e'(inst_i[31:26]);
    assign fn       = funct_e'(inst_i[5:0]);
    assign rd       = inst_i[15:11];
    assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_zext = {16'h0000, inst_i[15:0]};

    always_comb begin
        known            = 1'b1;
        use_rd           = 1'b0;
        ctrl_o           = '0;
        ctrl_o.rs        = inst_i[25:21];
        ctrl_o.rt        = inst_i[20:16];
        ctrl_o.src_b_imm = 1'b1;
        ctrl_o.imm_value = imm_zext;
        case (op)
            OP_SPECIAL: begin
                use_rd           = 1'b1;
                ctrl_o.src_b_imm = 1'b0;
                // shifts take shamt as operand a
                ctrl_o.src_a_shamt = (fn == FN_SLL) || (fn == FN_SRL) || (fn == FN_SRA);
                case (fn)
                    FN_ADDU: ctrl_o.alu_op = ALU_ADD;
                    FN_SUBU: ctrl_o.alu_op = ALU_SUB;
                    FN_AND:  ctrl_o.alu_op = ALU_AND;
                    FN_OR:   ctrl_o.alu_op = ALU_OR;
                    FN_XOR:  ctrl_o.alu_op = ALU_XOR;
                    FN_NOR:  ctrl_o.alu_op = ALU_NOR;
                    FN_SLT:  ctrl_o.alu_op = ALU_SLT;
                    FN_SLTU: ctrl_o.alu_op = ALU_SLTU;
                    FN_SLL:  ctrl_o.alu_op = ALU_SLL;
                    FN_SRL:  ctrl_o.alu_op = ALU_SRL;
                    FN_SRA:  ctrl_o.alu_op = ALU_SRA;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl_o.alu_op    = ALU_ADD;
                ctrl_o.imm_value = imm_sext;
            end
            OP_SLTI: begin
                ctrl_o.alu_op    = ALU_SLT;
                ctrl_o.imm_value = imm_sext;
            end
            OP_SLTIU: begin
                ctrl_o.alu_op    = ALU_SLTU;
                ctrl_o.imm_value = imm_sext;
            end
            OP_ANDI: ctrl_o.alu_op = ALU_AND;
            OP_ORI:  ctrl_o.alu_op = ALU_OR;
            OP_XORI: ctrl_o.alu_op = ALU_XOR;
            OP_LUI:  ctrl_o.alu_op = ALU_LUI;
            default: known = 1'b0;
        endcase
        ctrl_o.reg_waddr = use_rd ? rd : ctrl_o.rt;
        // undefined words and r0 writes retire without a write
        ctrl_o.reg_wen = known && (ctrl_o.reg_waddr != '0);
    end

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                clk,
    input  logic                rst_n_i,
    input  core_pkg::reg_addr_t ra_a_i,
    input  core_pkg::reg_addr_t ra_b_i,
    output core_pkg::word_t     rd_a_o,
    output core_pkg::word_t     rd_b_o,
    input  logic                wen_i,
    input  core_pkg::reg_addr_t waddr_i,
    input  core_pkg::word_t     wdata_i
);
    import core_pkg::*;

    word_t regs [NUM_REGS];
    logic  wr_live;

    assign wr_live = wen_i && (waddr_i != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through to same-cycle readers
    assign rd_a_o = (ra_a_i == '0) ? '0 : (wr_live && ra_a_i == waddr_i) ? wdata_i : regs[ra_a_i];
    assign rd_b_o = (ra_b_i == '0) ? '0 : (wr_live && ra_b_i == waddr_i) ? wdata_i : regs[ra_b_i];

endmodule

`default_nettype wire

// ==== hw/operand_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  core_pkg::reg_addr_t rs_i,
    input  core_pkg::reg_addr_t rt_i,
    input  core_pkg::word_t     rs_data_i,
    input  core_pkg::word_t     rt_data_i,
    input  logic                e_wen_i,
    input  core_pkg::reg_addr_t e_waddr_i,
    input  core_pkg::word_t     e_result_i,
    input  logic                w_wen_i,
    input  core_pkg::reg_addr_t w_waddr_i,
    input  core_pkg::word_t     w_result_i,
    output core_pkg::word_t     rs_value_o,
    output core_pkg::word_t     rt_value_o
);
    import core_pkg::*;

    // youngest producer wins, r0 stays from the regfile
    function automatic word_t resolve(reg_addr_t src, word_t rf_data);
        word_t value;
        value = rf_data;
        if (src != '0) begin
            if (e_wen_i && e_waddr_i == src) begin
                value = e_result_i;
            end else if (w_wen_i && w_waddr_i == src) begin
                value = w_result_i;
            end
        end
        return value;
    endfunction

    always_comb begin
        rs_value_o = resolve(rs_i, rs_data_i);
        rt_value_o = resolve(rt_i, rt_data_i);
    end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  isa_pkg::alu_op_e op_i,
    input  core_pkg::word_t  a_i,
    input  core_pkg::word_t  b_i,
    output core_pkg::word_t  y_o
);
    import core_pkg::*;
    import isa_pkg::*;

    logic [4:0] sa;

    // shift amount from the low bits of a
    assign sa = a_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  y_o = a_i + b_i;
            ALU_SUB:  y_o = a_i - b_i;
            ALU_AND:  y_o = a_i & b_i;
            ALU_OR:   y_o = a_i | b_i;
            ALU_XOR:  y_o = a_i ^ b_i;
            ALU_NOR:  y_o = ~(a_i | b_i);
            ALU_SLT:  y_o = {31'd0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: y_o = {31'd0, a_i < b_i};
            ALU_SLL:  y_o = b_i << sa;
            ALU_SRL:  y_o = b_i >> sa;
            ALU_SRA:  y_o = $signed(b_i) >>> sa;
            ALU_LUI:  y_o = {b_i[15:0], 16'h0000};
            default:  y_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/mips_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_datapath (
    input  logic                clk,
    input  logic                rst_n_i,
    output logic                inst_req_o,
    output core_pkg::word_t     inst_addr_o,
    input  logic                inst_data_ok_i,
    input  core_pkg::word_t     inst_rdata_i,
    output core_pkg::word_t     debug_wb_pc_o,
    output logic [3:0]          debug_wb_rf_wen_o,
    output core_pkg::reg_addr_t debug_wb_rf_wnum_o,
    output core_pkg::word_t     debug_wb_rf_wdata_o
);
    import core_pkg::*;
    import isa_pkg::*;

    fetch_pkt_t f_pkt;
    fetch_pkt_t d_q;
    dec_ctrl_t  d_ctrl;
    word_t      rs_data;
    word_t      rt_data;
    word_t      rs_value;
    word_t      rt_value;
    exe_pkt_t   e_next;
    exe_pkt_t   e_q;
    word_t      e_result;
    wb_pkt_t    w_next;
    wb_pkt_t    w_q;
    logic       w_write;

    pc_fetch u_pc_fetch (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_data_ok_i (inst_data_ok_i),
        .inst_rdata_i   (inst_rdata_i),
        .inst_req_o     (inst_req_o),
        .inst_addr_o    (inst_addr_o),
        .fetch_o        (f_pkt)
    );

    inst_decoder u_inst_decoder (
        .inst_i (d_q.inst),
        .ctrl_o (d_ctrl)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ra_a_i  (d_ctrl.rs),
        .ra_b_i  (d_ctrl.rt),
        .rd_a_o  (rs_data),
        .rd_b_o  (rt_data),
        .wen_i   (w_write),
        .waddr_i (w_q.reg_waddr),
        .wdata_i (w_q.result)
    );

    operand_forward u_operand_forward (
        .rs_i       (d_ctrl.rs),
        .rt_i       (d_ctrl.rt),
        .rs_data_i  (rs_data),
        .rt_data_i  (rt_data),
        .e_wen_i    (e_q.valid & e_q.reg_wen),
        .e_waddr_i  (e_q.reg_waddr),
        .e_result_i (e_result),
        .w_wen_i    (w_write),
        .w_waddr_i  (w_q.reg_waddr),
        .w_result_i (w_q.result),
        .rs_value_o (rs_value),
        .rt_value_o (rt_value)
    );

    alu u_alu (
        .op_i (e_q.alu_op),
        .a_i  (e_q.src_a),
        .b_i  (e_q.src_b),
        .y_o  (e_result)
    );

    // operand selects for the e stage
    always_comb begin
        e_next.valid     = d_q.valid;
        e_next.pc        = d_q.pc;
        e_next.alu_op    = d_ctrl.alu_op;
        e_next.src_a     = d_ctrl.src_a_shamt ? {27'd0, d_q.inst[10:6]} : rs_value;
        e_next.src_b     = d_ctrl.src_b_imm ? d_ctrl.imm_value : rt_value;
        e_next.reg_wen   = d_ctrl.reg_wen;
        e_next.reg_waddr = d_ctrl.reg_waddr;
    end

    assign w_next = '{
        valid:     e_q.valid,
        pc:        e_q.pc,
        reg_wen:   e_q.reg_wen,
        reg_waddr: e_q.reg_waddr,
        result:    e_result
    };

    // no back-pressure, every stage advances each cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            d_q.valid <= 1'b0;
            e_q.valid <= 1'b0;
            w_q.valid <= 1'b0;
        end else begin
            d_q <= f_pkt;
            e_q <= e_next;
            w_q <= w_next;
        end
    end

    assign w_write = w_q.valid & w_q.reg_wen;

    // writeback trace, pc reads zero for bubbles
    assign debug_wb_pc_o       = w_q.valid ? w_q.pc : '0;
    assign debug_wb_rf_wen_o   = {4{w_write}};
    assign debug_wb_rf_wnum_o  = w_q.reg_waddr;
    assign debug_wb_rf_wdata_o = w_q.result;

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, like every other input
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/mips_datapath_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_datapath_assert (
    input logic                clk,
    input logic                rst_n_i,
    input logic                inst_req_i,
    input core_pkg::word_t     inst_addr_i,
    input logic                inst_data_ok_i,
    input logic [3:0]          wb_wen_i,
    input core_pkg::reg_addr_t wb_wnum_i
);
    int unsigned fail_count = 0;

    // address held until the memory answers
    addr_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        (inst_req_i && !inst_data_ok_i) |=> $stable(inst_addr_i))
    else begin
        $error("fetch address changed while the request was still waiting");
        fail_count++;
    end

    wen_low_in_reset: assert property (@(posedge clk)
        !rst_n_i |=> (wb_wen_i == 4'b0000))
    else begin
        $error("register write enable set during reset");
        fail_count++;
    end

    no_r0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        (wb_wen_i != 4'b0000) |-> (wb_wnum_i != '0))
    else begin
        $error("traced write to register 0");
        fail_count++;
    end

endmodule

bind mips_datapath mips_datapath_assert u_assert (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .inst_req_i     (inst_req_o),
    .inst_addr_i    (inst_addr_o),
    .inst_data_ok_i (inst_data_ok_i),
    .wb_wen_i       (debug_wb_rf_wen_o),
    .wb_wnum_i      (debug_wb_rf_wnum_o)
);

`default_nettype wire

// ==== bench/mips_datapath_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_datapath_tb;
    import core_pkg::*;

    localparam int CLK_PERIOD_NS = 40;
    localparam int NUM_INSTS     = 22;
    // four cycles per instruction plus pipeline fill
    localparam int WATCHDOG_NS   = (NUM_INSTS * 4 + 20) * CLK_PERIOD_NS;

    logic       clk;
    logic       rst_n;
    logic       inst_req;
    word_t      inst_addr;
    logic       inst_data_ok;
    word_t      inst_rdata;
    word_t      wb_pc;
    logic [3:0] wb_wen;
    reg_addr_t  wb_wnum;
    word_t      wb_wdata;

    // inst word, expected dest and expected data for each instruction
    word_t pattern [3 * NUM_INSTS];
    int    seed = 70;
    int    test_errors = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(4)) u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mips_datapath DUT (
        .clk                 (clk),
        .rst_n_i             (rst_n),
        .inst_req_o          (inst_req),
        .inst_addr_o         (inst_addr),
        .inst_data_ok_i      (inst_data_ok),
        .inst_rdata_i        (inst_rdata),
        .debug_wb_pc_o       (wb_pc),
        .debug_wb_rf_wen_o   (wb_wen),
        .debug_wb_rf_wnum_o  (wb_wnum),
        .debug_wb_rf_wdata_o (wb_wdata)
    );

    task automatic check_word(input string test, input string what,
                              input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("FAIL %s %s: expected 0x%08h, actual 0x%08h", test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_reg_addr(input string test, input reg_addr_t exp,
                                  input reg_addr_t act);
        if (exp !== act) begin
            $display("FAIL %s wnum: expected %0d, actual %0d", test, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_wen(input string test, input logic [3:0] exp, input logic [3:0] act);
        if (exp !== act) begin
            $display("FAIL %s wen: expected %b, actual %b", test, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_req(input string test, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAIL %s req: expected %b, actual %b", test, exp, act);
            test_errors++;
        end
    endtask

    task automatic close_test(input string test);
        if (test_errors == 0) begin
            tests_passed++;
            $display("passed %s", test);
        end else begin
            tests_failed++;
            $display("failed %s (%0d mismatches)", test, test_errors);
        end
        test_errors = 0;
    endtask

    // past the program the memory returns nops
    function automatic word_t inst_at(input word_t addr);
        word_t slot;
        slot = (addr - RESET_PC) >> 2;
        if (slot < NUM_INSTS) begin
            return pattern[3 * slot];
        end
        return '0;
    endfunction

    task automatic first_fetch_test();
        @(negedge clk);
        while (!rst_n || !inst_req) begin
            if (!rst_n) begin
                check_req("reset", 1'b0, inst_req);
            end
            @(negedge clk);
        end
        check_word("reset", "first request address", RESET_PC, inst_addr);
        close_test("reset");
    endtask

    // bubbles show pc zero and must not write
    task automatic wait_for_retire(input string test);
        @(negedge clk);
        while (wb_pc == '0) begin
            if (wb_wen != 4'b0000) begin
                $display("%s: register write traced while no instruction retires", test);
                test_errors++;
            end
            @(negedge clk);
        end
    endtask

    task automatic retire_test(input int idx);
        string     test;
        reg_addr_t exp_dest;
        test     = $sformatf("inst%0d", idx);
        exp_dest = pattern[3 * idx + 1][4:0];
        wait_for_retire(test);
        check_word(test, "pc", RESET_PC + 32'(4 * idx), wb_pc);
        if (exp_dest == '0) begin
            check_wen(test, 4'b0000, wb_wen);
        end else begin
            check_wen(test, 4'b1111, wb_wen);
            check_reg_addr(test, exp_dest, wb_wnum);
            check_word(test, "data", pattern[3 * idx + 2], wb_wdata);
        end
        close_test(test);
    endtask

    // instruction memory answers after 0 to 2 idle cycles
    initial begin : imem_model
        int idle_left;
        inst_data_ok = 1'b0;
        inst_rdata   = '0;
        idle_left    = $unsigned($random(seed)) % 3;
        forever begin
            @(negedge clk);
            if (!rst_n || !inst_req) begin
                inst_data_ok = 1'b0;
            end else if (idle_left > 0) begin
                idle_left--;
                inst_data_ok = 1'b0;
            end else begin
                inst_data_ok = 1'b1;
                inst_rdata   = inst_at(inst_addr);
                idle_left    = $unsigned($random(seed)) % 3;
            end
        end
    end

    initial begin : run_tests
        $readmemh("bench/datapath_patterns.hex", pattern);
        first_fetch_test();
        for (int i = 0; i < NUM_INSTS; i++) begin
            retire_test(i);
        end
        $display("tests: %0d, passed: %0d, failed: %0d",
                 NUM_INSTS + 1, tests_passed, tests_failed);
        if (tests_failed == 0 && DUT.u_assert.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: not all %0d instructions retired within %0d ns",
                 NUM_INSTS, WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/datapath_patterns.hex ====
// columns: instruction word, expected destination register (0 = no write), expected data
// program starts at the reset vector, one instruction per line
3C018000 00000001 80000000
342100F0 00000001 800000F0
2402FFFD 00000002 FFFFFFFD
00221821 00000003 800000ED
00412023 00000004 7FFFFF0D
00642824 00000005 0000000D
00643025 00000006 FFFFFFED
00C13826 00000007 7FFFFF1D
00A04027 00000008 FFFFFFF2
0025482A 00000009 00000001
0025502B 0000000A 00000000
00015903 0000000B F800000F
000B6202 0000000C 00F80000
000C68C0 0000000D 07C00000
284EFFFE 0000000E 00000001
2C2FFFFF 0000000F 00000001
30F0FF00 00000010 0000FF00
3A118001 00000011 00007F01
24200005 00000000 00000000
FC000000 00000000 00000000
00220018 00000000 00000000
00119021 00000012 00007F01

// ==== mips_datapath.f ====
hw/core_pkg.sv
hw/isa_pkg.sv
hw/pc_fetch.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/operand_forward.sv
hw/alu.sv
hw/mips_datapath.sv
bench/tb_clock_gen.sv
bench/mips_datapath_assert.sv
bench/mips_datapath_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module mips_datapath_tb -f mips_datapath.f
if [ $? -ne 0 ]; then
    echo "run.sh: Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vmips_datapath_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "run.sh: simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Everything OK"; then
    exit 0
fi
echo "run.sh: pass message not found"
exit 1
